//--- rtl/io_map_pkg.sv
package io_map_pkg;

    // Bus word, word address and byte lanes
    typedef logic [31:0] word_t;
    typedef logic [13:0] io_addr_t;
    typedef logic [3:0]  byte_en_t;

    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  led_t;

    // Word addresses
    localparam io_addr_t ADDR_UART_STATUS  = 14'd0;
    localparam io_addr_t ADDR_UART_RX      = 14'd1;
    localparam io_addr_t ADDR_UART_TX      = 14'd2;
    localparam io_addr_t ADDR_CYCLES       = 14'd4;
    localparam io_addr_t ADDR_RETIRED      = 14'd5;
    localparam io_addr_t ADDR_COUNT_CLEAR  = 14'd6;
    localparam io_addr_t ADDR_BTN_EMPTY    = 14'd8;
    localparam io_addr_t ADDR_BTN_DATA     = 14'd9;
    localparam io_addr_t ADDR_SWITCHES     = 14'd10;
    localparam io_addr_t ADDR_LEDS         = 14'd12;
    localparam io_addr_t ADDR_CARRIER_BASE = 14'd64;
    localparam io_addr_t ADDR_MOD_FCW      = 14'd128;
    localparam io_addr_t ADDR_MOD_SHIFT    = 14'd129;
    localparam io_addr_t ADDR_NOTE_EN      = 14'd130;
    localparam io_addr_t ADDR_TX_REQ       = 14'd132;
    localparam io_addr_t ADDR_TX_ACK       = 14'd133;

endpackage

//--- rtl/synth_pkg.sv
package synth_pkg;

    // NCO frequency control word
    typedef logic [23:0] fcw_t;

    // Modulator shift term
    typedef logic [4:0] shift_t;

    localparam int NUM_CARRIERS = 4;

    // One enable bit per carrier
    typedef logic [NUM_CARRIERS-1:0] note_mask_t;

endpackage

//--- rtl/button_fifo.sv
`timescale 1ns/1ps

module button_fifo #(
    parameter int FIFO_DEPTH  = 8,
    parameter int NUM_BUTTONS = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_BUTTONS-1:0] buttons,
    input  logic                   pop,
    output logic [NUM_BUTTONS-1:0] head,
    output logic                   empty
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [NUM_BUTTONS-1:0] buttons_q;
    logic [NUM_BUTTONS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   full;
    logic                   push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // Any rising edge captures the whole vector, dropped when full
    assign push = |(buttons & ~buttons_q) && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            buttons_q <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
        end else begin
            buttons_q <= buttons;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= buttons;
        end
    end

    // Top level must gate the pop with the empty flag
    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- rtl/uart_port.sv
`timescale 1ns/1ps

module uart_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              tx_write,
    input  io_map_pkg::byte_t wdata,
    output io_map_pkg::byte_t tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,
    input  logic              rx_pop,
    output logic              rx_ready
);

    // Transmit byte and pending flag
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_data  <= '0;
            tx_valid <= 1'b0;
        end else if (tx_write) begin
            tx_data  <= wdata;
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    // One pulse per read of the receive word
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= rx_pop;
        end
    end

    no_write_while_pending: assert property (
        @(posedge clk) disable iff (rst) tx_write |-> !tx_valid
    );

endmodule

//--- rtl/perf_counters.sv
`timescale 1ns/1ps

module perf_counters (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              retire,
    output io_map_pkg::word_t cycles,
    output io_map_pkg::word_t retired
);

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1;
        end
    end

    // Counts only cycles where an instruction retires
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            retired <= '0;
        end else if (retire) begin
            retired <= retired + 1'b1;
        end
    end

endmodule

//--- rtl/synth_regs.sv
`timescale 1ns/1ps

module synth_regs (
    input  logic                                          clk,
    input  logic                                          rst,
    input  io_map_pkg::io_addr_t                          io_addr,
    input  io_map_pkg::word_t                             io_wdata,
    input  io_map_pkg::byte_en_t                          io_we,
    output synth_pkg::fcw_t [synth_pkg::NUM_CARRIERS-1:0] carrier_fcw,
    output synth_pkg::fcw_t                               mod_fcw,
    output synth_pkg::shift_t                             mod_shift,
    output synth_pkg::note_mask_t                         note_enable,
    output logic                                          tx_req
);
    import io_map_pkg::*;
    import synth_pkg::*;

    // Lane 3 has no storage behind it
    function automatic fcw_t merge_fcw(input fcw_t cur, input word_t wdata, input byte_en_t be);
        fcw_t merged;
        merged = cur;
        for (int b = 0; b < $bits(fcw_t) / 8; b++) begin
            if (be[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            carrier_fcw <= '0;
            mod_fcw     <= '0;
            mod_shift   <= '0;
            note_enable <= '0;
            tx_req      <= 1'b0;
        end else begin
            for (int c = 0; c < NUM_CARRIERS; c++) begin
                if (io_addr == io_addr_t'(ADDR_CARRIER_BASE + c)) begin
                    carrier_fcw[c] <= merge_fcw(carrier_fcw[c], io_wdata, io_we);
                end
            end
            if (io_addr == ADDR_MOD_FCW) begin
                mod_fcw <= merge_fcw(mod_fcw, io_wdata, io_we);
            end
            // Narrow registers take byte 0 only
            if (io_we[0]) begin
                case (io_addr)
                    ADDR_MOD_SHIFT: mod_shift   <= io_wdata[$bits(shift_t)-1:0];
                    ADDR_NOTE_EN:   note_enable <= io_wdata[NUM_CARRIERS-1:0];
                    ADDR_TX_REQ:    tx_req      <= io_wdata[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- rtl/io_block.sv
`timescale 1ns/1ps

module io_block #(
    parameter int FIFO_DEPTH  = 8,
    parameter int NUM_BUTTONS = 3
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  io_map_pkg::io_addr_t                          io_addr,
    input  io_map_pkg::word_t                             io_wdata,
    input  io_map_pkg::byte_en_t                          io_we,
    input  logic                                          io_rd,
    output io_map_pkg::word_t                             io_rdata,
    input  logic                                          retire,
    input  io_map_pkg::byte_t                             rx_data,
    input  logic                                          rx_valid,
    output logic                                          rx_ready,
    output io_map_pkg::byte_t                             tx_data,
    output logic                                          tx_valid,
    input  logic                                          tx_ready,
    input  logic [NUM_BUTTONS-1:0]                        buttons,
    input  logic [1:0]                                    switches,
    output io_map_pkg::led_t                              leds,
    output synth_pkg::fcw_t [synth_pkg::NUM_CARRIERS-1:0] carrier_fcw,
    output synth_pkg::fcw_t                               mod_fcw,
    output synth_pkg::shift_t                             mod_shift,
    output synth_pkg::note_mask_t                         note_enable,
    output logic                                          tx_req,
    input  logic                                          tx_ack
);
    import io_map_pkg::*;
    import synth_pkg::*;

    logic                   tx_write;
    logic                   rx_pop;
    logic                   btn_pop;
    logic                   count_clear;
    logic                   led_write;
    logic                   btn_empty;
    logic [NUM_BUTTONS-1:0] btn_head;
    word_t                  cycles;
    word_t                  retired;
    word_t                  rd_word;

    // Per-block strobes
    assign tx_write    = io_we[0] && (io_addr == ADDR_UART_TX);
    assign led_write   = io_we[0] && (io_addr == ADDR_LEDS);
    assign count_clear = (|io_we) && (io_addr == ADDR_COUNT_CLEAR);
    assign rx_pop      = io_rd && (io_addr == ADDR_UART_RX);
    assign btn_pop     = io_rd && (io_addr == ADDR_BTN_DATA) && !btn_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            leds <= '0;
        end else if (led_write) begin
            leds <= io_wdata[$bits(led_t)-1:0];
        end
    end

    always_comb begin
        rd_word = '0;
        case (io_addr)
            ADDR_UART_STATUS: rd_word = {30'b0, rx_valid, tx_ready};
            ADDR_UART_RX:     rd_word = word_t'(rx_data);
            ADDR_UART_TX:     rd_word = word_t'(tx_data);
            ADDR_CYCLES:      rd_word = cycles;
            ADDR_RETIRED:     rd_word = retired;
            ADDR_BTN_EMPTY:   rd_word = word_t'(btn_empty);
            ADDR_BTN_DATA:    rd_word = btn_empty ? '0 : word_t'(btn_head);
            ADDR_SWITCHES:    rd_word = word_t'(switches);
            ADDR_LEDS:        rd_word = word_t'(leds);
            ADDR_MOD_FCW:     rd_word = word_t'(mod_fcw);
            ADDR_MOD_SHIFT:   rd_word = word_t'(mod_shift);
            ADDR_NOTE_EN:     rd_word = word_t'(note_enable);
            ADDR_TX_REQ:      rd_word = word_t'(tx_req);
            ADDR_TX_ACK:      rd_word = word_t'(tx_ack);
            default: begin
                for (int c = 0; c < NUM_CARRIERS; c++) begin
                    if (io_addr == io_addr_t'(ADDR_CARRIER_BASE + c)) begin
                        rd_word = word_t'(carrier_fcw[c]);
                    end
                end
            end
        endcase
    end

    // Read data holds until the next strobe
    always_ff @(posedge clk) begin
        if (io_rd) begin
            io_rdata <= rd_word;
        end
    end

    button_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .NUM_BUTTONS(NUM_BUTTONS)
    ) button_fifo_i (
        .clk    (clk),
        .rst    (rst),
        .buttons(buttons),
        .pop    (btn_pop),
        .head   (btn_head),
        .empty  (btn_empty)
    );

    uart_port uart_port_i (
        .clk     (clk),
        .rst     (rst),
        .tx_write(tx_write),
        .wdata   (io_wdata[7:0]),
        .tx_data (tx_data),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .rx_pop  (rx_pop),
        .rx_ready(rx_ready)
    );

    perf_counters perf_counters_i (
        .clk    (clk),
        .rst    (rst),
        .clear  (count_clear),
        .retire (retire),
        .cycles (cycles),
        .retired(retired)
    );

    synth_regs synth_regs_i (
        .clk        (clk),
        .rst        (rst),
        .io_addr    (io_addr),
        .io_wdata   (io_wdata),
        .io_we      (io_we),
        .carrier_fcw(carrier_fcw),
        .mod_fcw    (mod_fcw),
        .mod_shift  (mod_shift),
        .note_enable(note_enable),
        .tx_req     (tx_req)
    );

    rd_we_exclusive: assert property (@(posedge clk) disable iff (rst) !(io_rd && |io_we));

endmodule

//--- verif/io_checker.sv
`timescale 1ns/1ps

module io_checker #(
    parameter int OUT_W = 146
) (
    input  logic              clk,
    input  logic              rst,
    input  io_map_pkg::word_t io_rdata,
    input  io_map_pkg::word_t exp_rdata,
    input  logic              rd_seen,
    input  logic [OUT_W-1:0]  dut_outs,
    input  logic [OUT_W-1:0]  exp_outs,
    output int                errors,
    output int                checks
);

    initial begin
        errors = 0;
        checks = 0;
    end

    // Mid-cycle sample, away from the edge where DUT and model update
    always @(negedge clk) begin
        if (!rst) begin
            checks = checks + 1;
            if (dut_outs !== exp_outs) begin
                errors = errors + 1;
                $display("Fail at %0t: output ports %h, expected %h", $time, dut_outs, exp_outs);
            end
            // Read data is held, so it is checked every cycle after the first read
            if (rd_seen) begin
                checks = checks + 1;
                if (io_rdata !== exp_rdata) begin
                    errors = errors + 1;
                    $display("Fail at %0t: read data %h, expected %h", $time, io_rdata, exp_rdata);
                end
            end
        end
    end

endmodule

//--- verif/io_block_tb.sv
`timescale 1ns/1ps

module io_block_tb;
    import io_map_pkg::*;
    import synth_pkg::*;

    localparam int FIFO_DEPTH  = 8;
    localparam int NUM_BUTTONS = 3;
    localparam int TEST_LEN    = 300;
    localparam int TIMEOUT     = 10 + 6 * (TEST_LEN + 1) + 50;
    localparam int OUT_W       = $bits(byte_t) + 2 + $bits(led_t) + $bits(shift_t)
                                 + (NUM_CARRIERS + 1) * $bits(fcw_t) + NUM_CARRIERS + 1;

    logic clk = 1'b0;
    logic rst = 1'b1;
    io_addr_t io_addr = '0;
    word_t io_wdata = '0;
    byte_en_t io_we = '0;
    byte_t rx_data = '0;
    logic io_rd = 1'b0;
    logic retire = 1'b0;
    logic rx_valid = 1'b0;
    logic tx_ready = 1'b0;
    logic tx_ack = 1'b0;
    logic [NUM_BUTTONS-1:0] buttons = '0;
    logic [1:0] switches = '0;
    word_t io_rdata;
    byte_t tx_data;
    logic rx_ready, tx_valid, tx_req;
    led_t leds;
    fcw_t [NUM_CARRIERS-1:0] carrier_fcw;
    fcw_t mod_fcw;
    shift_t mod_shift;
    note_mask_t note_enable;

    // Reference model state
    fcw_t [NUM_CARRIERS-1:0] m_carrier;
    fcw_t m_mod_fcw;
    shift_t m_shift;
    note_mask_t m_note;
    led_t m_leds;
    byte_t m_tx_data;
    logic m_tx_valid, m_rx_ready, m_tx_req;
    logic rd_seen = 1'b0;
    logic [NUM_BUTTONS-1:0] m_btn_prev;
    logic [NUM_BUTTONS-1:0] btn_q[$];
    word_t m_cycles, m_retired, exp_rdata;

    logic [31:0] lfsr = 32'hfb17;
    int errors, checks;
    int cycle_count = 0;

    always #50 clk = ~clk;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Address pool of each test
    function automatic io_addr_t pick_addr(input int test);
        logic [2:0] idx;
        idx = random_bits(3);
        case (test)
            1: return (idx < 4) ? ADDR_CARRIER_BASE + idx
                                : (idx == 7) ? ADDR_TX_REQ : ADDR_MOD_FCW + idx - 4;
            2: return idx[1] ? io_addr_t'(random_bits(14) | 14'h100)
                             : (idx[0] ? ADDR_SWITCHES : ADDR_LEDS);
            3: return idx[1] ? ADDR_UART_TX : (idx[0] ? ADDR_UART_RX : ADDR_UART_STATUS);
            4: return (idx[1:0] == 2'd0) ? ADDR_BTN_EMPTY : ADDR_BTN_DATA;
            5: return (idx == 3'd0) ? ADDR_COUNT_CLEAR : (idx[0] ? ADDR_CYCLES : ADDR_RETIRED);
            default: return idx[0] ? ADDR_TX_REQ : ADDR_TX_ACK;
        endcase
    endfunction

    function automatic word_t expected_read(input io_addr_t addr);
        case (addr)
            ADDR_UART_STATUS: return {30'b0, rx_valid, tx_ready};
            ADDR_UART_RX:     return word_t'(rx_data);
            ADDR_UART_TX:     return word_t'(m_tx_data);
            ADDR_CYCLES:      return m_cycles;
            ADDR_RETIRED:     return m_retired;
            ADDR_BTN_EMPTY:   return word_t'(btn_q.size() == 0);
            ADDR_BTN_DATA:    return (btn_q.size() == 0) ? '0 : word_t'(btn_q[0]);
            ADDR_SWITCHES:    return word_t'(switches);
            ADDR_LEDS:        return word_t'(m_leds);
            ADDR_MOD_FCW:     return word_t'(m_mod_fcw);
            ADDR_MOD_SHIFT:   return word_t'(m_shift);
            ADDR_NOTE_EN:     return word_t'(m_note);
            ADDR_TX_REQ:      return word_t'(m_tx_req);
            ADDR_TX_ACK:      return word_t'(tx_ack);
            default: begin
                if (addr >= ADDR_CARRIER_BASE && addr < ADDR_CARRIER_BASE + NUM_CARRIERS) begin
                    return word_t'(m_carrier[addr - ADDR_CARRIER_BASE]);
                end
                return '0;
            end
        endcase
    endfunction

    // Masked byte merge truncated to the 24 stored bits
    function automatic fcw_t merged_fcw(input fcw_t old);
        word_t mask;
        mask = {{8{io_we[3]}}, {8{io_we[2]}}, {8{io_we[1]}}, {8{io_we[0]}}};
        return fcw_t'((word_t'(old) & ~mask) | (io_wdata & mask));
    endfunction

    task automatic update_model();
        logic full;
        if (io_rd) begin
            exp_rdata = expected_read(io_addr);
            rd_seen = 1'b1;
        end
        m_rx_ready = io_rd && (io_addr == ADDR_UART_RX);
        full = (btn_q.size() == FIFO_DEPTH);
        if (io_rd && io_addr == ADDR_BTN_DATA && btn_q.size() != 0) begin
            btn_q.delete(0);
        end
        if (|(buttons & ~m_btn_prev) && !full) begin
            btn_q.push_back(buttons);
        end
        m_btn_prev = buttons;
        if (|io_we && io_addr == ADDR_COUNT_CLEAR) begin
            m_cycles = '0;
            m_retired = '0;
        end else begin
            m_cycles = m_cycles + 1;
            m_retired = m_retired + retire;
        end
        if (io_we[0] && io_addr == ADDR_UART_TX) begin
            m_tx_data = io_wdata[7:0];
            m_tx_valid = 1'b1;
        end else if (tx_ready) begin
            m_tx_valid = 1'b0;
        end
        for (int c = 0; c < NUM_CARRIERS; c++) begin
            if (io_addr == ADDR_CARRIER_BASE + c) begin
                m_carrier[c] = merged_fcw(m_carrier[c]);
            end
        end
        if (io_addr == ADDR_MOD_FCW) begin
            m_mod_fcw = merged_fcw(m_mod_fcw);
        end
        if (io_we[0]) begin
            case (io_addr)
                ADDR_LEDS:      m_leds = io_wdata[5:0];
                ADDR_MOD_SHIFT: m_shift = io_wdata[4:0];
                ADDR_NOTE_EN:   m_note = io_wdata[3:0];
                ADDR_TX_REQ:    m_tx_req = io_wdata[0];
                default: ;
            endcase
        end
    endtask

    // Model catches up with what the DUT sampled at the clock edge
    task automatic step();
        @(posedge clk);
        #1;
        if (rst) begin
            {m_carrier, m_mod_fcw, m_shift, m_note, m_leds, m_tx_data} = '0;
            {m_tx_valid, m_rx_ready, m_tx_req, m_btn_prev, m_cycles, m_retired} = '0;
            btn_q.delete();
        end else begin
            update_model();
        end
    endtask

    task automatic random_access(input int test);
        io_addr = pick_addr(test);
        io_rd = random_bits(1);
        // Transmit word may only be written while nothing is pending
        if (io_addr == ADDR_UART_TX && m_tx_valid) begin
            io_rd = 1'b1;
        end
        io_we = io_rd ? '0 : byte_en_t'(random_bits(4));
        io_wdata = random_bits(32);
        {retire, rx_valid, tx_ready, tx_ack} = random_bits(4);
        rx_data = random_bits(8);
        switches = random_bits(2);
        if (test == 4) begin
            buttons = random_bits(NUM_BUTTONS);
        end
        step();
    endtask

    task automatic run_test(input int test, input string name);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        repeat (TEST_LEN) begin
            random_access(test);
        end
        io_rd = 1'b0;
        io_we = '0;
        step();
        $display("Test %0d %s: %0d checks, %0d errors", test, name, checks - chk0, errors - err0);
    endtask

    io_block #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .NUM_BUTTONS(NUM_BUTTONS)
    ) io_block_i (.*);

    io_checker #(
        .OUT_W(OUT_W)
    ) io_checker_i (
        .clk      (clk),
        .rst      (rst),
        .io_rdata (io_rdata),
        .exp_rdata(exp_rdata),
        .rd_seen  (rd_seen),
        .dut_outs ({tx_data, tx_valid, rx_ready, leds, carrier_fcw, mod_fcw, mod_shift,
                    note_enable, tx_req}),
        .exp_outs ({m_tx_data, m_tx_valid, m_rx_ready, m_leds, m_carrier, m_mod_fcw, m_shift,
                    m_note, m_tx_req}),
        .errors   (errors),
        .checks   (checks)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("The tests did not finish within %0d cycles, run stopped", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        repeat (10) begin
            step();
        end
        rst = 1'b0;
        run_test(1, "synthesizer registers");
        run_test(2, "leds, switches and unmapped words");
        run_test(3, "uart");
        run_test(4, "button fifo");
        run_test(5, "counters");
        run_test(6, "transmit request and ack");
        $display("Total checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/io_map_pkg.sv
rtl/synth_pkg.sv
rtl/button_fifo.sv
rtl/uart_port.sv
rtl/perf_counters.sv
rtl/synth_regs.sv
rtl/io_block.sv
verif/io_checker.sv
verif/io_block_tb.sv

//--- Bender.yml
package:
  name: io_block

sources:
  - files:
      - rtl/io_map_pkg.sv
      - rtl/synth_pkg.sv
      - rtl/button_fifo.sv
      - rtl/uart_port.sv
      - rtl/perf_counters.sv
      - rtl/synth_regs.sv
      - rtl/io_block.sv
  - target: test
    files:
      - verif/io_checker.sv
      - verif/io_block_tb.sv
